//--- source/predecode_params.svh
`ifndef PREDECODE_PARAMS_SVH
`define PREDECODE_PARAMS_SVH

// --------------------
// bundle geometry
// --------------------

// width of one parcel
`define PARCEL_BITS 16
// parcels carried by one fetch bundle
`define NUM_PARCELS 15
// bundle input width, parcels plus start marks
`define BUNDLE_BITS 256

// --------------------
// slot geometry
// --------------------

// parcels seen by one instruction window
`define WINDOW_PARCELS 5
`define MAX_INSTR 12
`define MAX_JUMPS 4

`endif

//--- source/isa_pkg.sv
`include "predecode_params.svh"

package isa_pkg;

  // --------------------
  // instruction encoding
  // --------------------

  // five parcels starting at the instruction's first parcel
  typedef logic [`WINDOW_PARCELS*`PARCEL_BITS-1:0] instrWindowT;

  // bit i set when parcel start+1+i continues the instruction
  typedef logic [`WINDOW_PARCELS-2:0] magicT;

  // main opcode, low byte of the window
  typedef logic [7:0] opcodeT;

  // --------------------
  // class vector
  // --------------------

  typedef enum logic [3:0] {
    classIndir = 4'd0,
    classJump  = 4'd1,
    classAlu   = 4'd2,
    classShift = 4'd3,
    classMul   = 4'd4,
    classLoad  = 4'd5,
    classStore = 4'd6,
    classSys   = 4'd7,
    classFlag  = 4'd8
  } iclassIdxE;

  typedef logic [classFlag:0] classT;

endpackage

//--- source/bundle_pkg.sv
`include "predecode_params.svh"

package bundle_pkg;

  // parcel k in bits 16k+15:16k, start marks from bit 240 up
  typedef logic [`BUNDLE_BITS-1:0] bundleT;

  // one bit per parcel
  typedef logic [`NUM_PARCELS-1:0] parcelMaskT;

  // parcel index, wide enough to hold one past the last parcel
  typedef logic [$clog2(`NUM_PARCELS+1)-1:0] parcelOffT;

  // --------------------
  // slot enables
  // --------------------

  typedef logic [`MAX_INSTR-1:0] instrEnT;
  typedef logic [`MAX_JUMPS-1:0] jumpEnT;

endpackage

//--- source/instrClassifier.sv
`timescale 1ns/1ps

module instrClassifier
  import isa_pkg::*;
(
  input  instrWindowT window,
  input  magicT       magic,
  input  logic        flag,
  output classT       instrClass
);

  opcodeT     opcode;
  logic [2:0] subOp;
  logic       isLong;

  // opcode groups
  logic isAluMul;
  logic isShift;
  logic isCmpTest;
  logic isLoadStore;
  logic isCondJump;
  logic isUncondJump;
  logic isIndirOp;
  logic isPtrMul;
  logic isSys;

  // forms of the indirect opcode
  logic indirForm;
  logic callForm;
  logic anyJump;

  assign opcode = window[7:0];
  assign subOp  = window[15:13];

  // one-parcel instructions are compressed forms, they carry no class
  assign isLong = magic[0];

  // --------------------
  // main opcode decode
  // --------------------

  assign isAluMul     = isLong && (opcode <= 8'd39);
  assign isShift      = isLong && (opcode >= 8'd40) && (opcode <= 8'd45);
  assign isCmpTest    = isLong && (opcode >= 8'd46) && (opcode <= 8'd53);
  assign isLoadStore  = isLong && (opcode[7:6] == 2'b01);
  assign isCondJump   = isLong && (opcode[7:4] == 4'b1010);
  assign isUncondJump = isLong && (opcode == 8'd181);
  assign isIndirOp    = isLong && (opcode == 8'd182);
  assign isPtrMul     = isLong && (opcode == 8'd212);
  assign isSys        = isLong && (opcode == 8'hff);

  // sub field 0 is indirect jump, 3 is return, 1 and 2 are calls
  assign indirForm = isIndirOp && ((subOp == 3'd0) || (subOp == 3'd3));
  assign callForm  = isIndirOp && ((subOp == 3'd1) || (subOp == 3'd2));

  assign anyJump = isCondJump || isUncondJump || indirForm || callForm;

  // --------------------
  // class vector
  // --------------------

  assign instrClass[classIndir] = indirForm;
  assign instrClass[classJump]  = anyJump;

  // conditional jumps also go through the ALU for the compare
  assign instrClass[classAlu] = (isAluMul && !opcode[2]) || isCmpTest || isCondJump;

  assign instrClass[classShift] = isShift;
  assign instrClass[classMul]   = (isAluMul && opcode[2]) || isPtrMul;

  // even opcodes load, odd opcodes store
  assign instrClass[classLoad] = isLoadStore && !opcode[0];

  // a call pushes its return address
  assign instrClass[classStore] = (isLoadStore && opcode[0]) || callForm;

  assign instrClass[classSys]  = isSys;
  assign instrClass[classFlag] = flag;

endmodule

//--- source/slotExtract.sv
`timescale 1ns/1ps
`include "predecode_params.svh"

module slotExtract
  import isa_pkg::*;
  import bundle_pkg::*;
(
  input  bundleT      bundle,
  input  parcelOffT   startOff,
  input  classT       instrClass [`NUM_PARCELS],
  output parcelMaskT  validStart,
  output instrWindowT window [`NUM_PARCELS],
  output magicT       magic [`NUM_PARCELS],
  output instrWindowT slotInstr [`MAX_INSTR],
  output magicT       slotMagic [`MAX_INSTR],
  output parcelOffT   slotOff [`MAX_INSTR],
  output classT       slotClass [`MAX_INSTR],
  output instrEnT     instrEn,
  output logic        error
);

  localparam int PayloadBits = `NUM_PARCELS * `PARCEL_BITS;
  localparam int PadBits     = (`WINDOW_PARCELS - 1) * `PARCEL_BITS;
  localparam int CntBits     = $clog2(`NUM_PARCELS + 1);

  // parcels with zeros past the end of the bundle
  logic [PayloadBits+PadBits-1:0] parcels;

  // start flag per parcel, positions past parcel 14 read as starts
  logic [`NUM_PARCELS+`WINDOW_PARCELS-2:0] startExt;

  logic [CntBits-1:0] startPos [`NUM_PARCELS];
  logic [CntBits-1:0] startCnt;

  assign parcels  = {{PadBits{1'b0}}, bundle[PayloadBits-1:0]};
  assign startExt = {{(`WINDOW_PARCELS-1){1'b1}}, bundle[PayloadBits +: `NUM_PARCELS-1], 1'b1};

  // --------------------
  // per-parcel decode
  // --------------------

  for (genvar k = 0; k < `NUM_PARCELS; k++) begin : gParcel
    assign window[k]     = parcels[k*`PARCEL_BITS +: `WINDOW_PARCELS*`PARCEL_BITS];
    assign magic[k]      = ~startExt[k+1 +: `WINDOW_PARCELS-1];
    assign validStart[k] = startExt[k] && (parcelOffT'(k) >= startOff);
  end

  // startPos[k] counts the valid starts below parcel k
  always_comb begin
    startCnt = '0;
    for (int k = 0; k < `NUM_PARCELS; k++) begin
      startPos[k] = startCnt;
      startCnt    = startCnt + CntBits'(validStart[k]);
    end
  end

  // --------------------
  // slot selection
  // --------------------

  always_comb begin
    for (int n = 0; n < `MAX_INSTR; n++) begin
      slotInstr[n] = '0;
      slotMagic[n] = '0;
      slotOff[n]   = '0;
      slotClass[n] = '0;
      for (int k = 0; k < `NUM_PARCELS; k++) begin
        if (validStart[k] && (startPos[k] == CntBits'(n))) begin
          slotInstr[n] = window[k];
          slotMagic[n] = magic[k];
          slotOff[n]   = parcelOffT'(k);
          slotClass[n] = instrClass[k];
        end
      end
      instrEn[n] = (startCnt > CntBits'(n));
    end
  end

  // too many instructions, or an offset past the last parcel
  assign error = (startCnt > CntBits'(`MAX_INSTR)) ||
                 (startOff == parcelOffT'(`NUM_PARCELS));

endmodule

//--- source/jumpExtract.sv
`timescale 1ns/1ps
`include "predecode_params.svh"

module jumpExtract
  import isa_pkg::*;
  import bundle_pkg::*;
(
  input  parcelMaskT  validStart,
  input  instrWindowT window [`NUM_PARCELS],
  input  magicT       magic [`NUM_PARCELS],
  input  classT       instrClass [`NUM_PARCELS],
  output instrWindowT jumpInstr [`MAX_JUMPS],
  output magicT       jumpMagic [`MAX_JUMPS],
  output parcelOffT   jumpOff [`MAX_JUMPS],
  output classT       jumpClass [`MAX_JUMPS],
  output jumpEnT      jumpEn,
  output logic        hasJumps,
  output logic        jumpError
);

  localparam int CntBits = $clog2(`NUM_PARCELS + 1);

  parcelMaskT         isJump;
  logic [CntBits-1:0] jumpPos [`NUM_PARCELS];
  logic [CntBits-1:0] jumpCnt;

  for (genvar k = 0; k < `NUM_PARCELS; k++) begin : gJump
    assign isJump[k] = validStart[k] && instrClass[k][classJump];
  end

  // running count of jumps below each parcel
  always_comb begin
    jumpCnt = '0;
    for (int k = 0; k < `NUM_PARCELS; k++) begin
      jumpPos[k] = jumpCnt;
      jumpCnt    = jumpCnt + CntBits'(isJump[k]);
    end
  end

  // --------------------
  // jump slots
  // --------------------

  always_comb begin
    for (int m = 0; m < `MAX_JUMPS; m++) begin
      jumpInstr[m] = '0;
      jumpMagic[m] = '0;
      jumpOff[m]   = '0;
      jumpClass[m] = '0;
      for (int k = 0; k < `NUM_PARCELS; k++) begin
        if (isJump[k] && (jumpPos[k] == CntBits'(m))) begin
          jumpInstr[m] = window[k];
          jumpMagic[m] = magic[k];
          jumpOff[m]   = parcelOffT'(k);
          jumpClass[m] = instrClass[k];
        end
      end
      jumpEn[m] = (jumpCnt > CntBits'(m));
    end
  end

  assign hasJumps  = |isJump;
  assign jumpError = (jumpCnt > CntBits'(`MAX_JUMPS));

endmodule

//--- source/predecodeOutReg.sv
`timescale 1ns/1ps
`include "predecode_params.svh"

module predecodeOutReg
  import isa_pkg::*;
  import bundle_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        bundleValid,
  input  instrWindowT slotInstr [`MAX_INSTR],
  input  magicT       slotMagic [`MAX_INSTR],
  input  parcelOffT   slotOff [`MAX_INSTR],
  input  classT       slotClass [`MAX_INSTR],
  input  instrEnT     instrEn,
  input  logic        error,
  input  instrWindowT jumpInstr [`MAX_JUMPS],
  input  magicT       jumpMagic [`MAX_JUMPS],
  input  parcelOffT   jumpOff [`MAX_JUMPS],
  input  classT       jumpClass [`MAX_JUMPS],
  input  jumpEnT      jumpEn,
  input  logic        hasJumps,
  input  logic        jumpError,
  output instrWindowT outSlotInstr [`MAX_INSTR],
  output magicT       outSlotMagic [`MAX_INSTR],
  output parcelOffT   outSlotOff [`MAX_INSTR],
  output classT       outSlotClass [`MAX_INSTR],
  output instrEnT     outInstrEn,
  output logic        outError,
  output instrWindowT outJumpInstr [`MAX_JUMPS],
  output magicT       outJumpMagic [`MAX_JUMPS],
  output parcelOffT   outJumpOff [`MAX_JUMPS],
  output classT       outJumpClass [`MAX_JUMPS],
  output jumpEnT      outJumpEn,
  output logic        outHasJumps,
  output logic        outJumpError,
  output logic        outValid
);

  // --------------------
  // enables and status
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid     <= 1'b0;
      outInstrEn   <= '0;
      outError     <= 1'b0;
      outJumpEn    <= '0;
      outHasJumps  <= 1'b0;
      outJumpError <= 1'b0;
    end else begin
      outValid <= bundleValid;
      if (bundleValid) begin
        outInstrEn   <= instrEn;
        outError     <= error;
        outJumpEn    <= jumpEn;
        outHasJumps  <= hasJumps;
        outJumpError <= jumpError;
      end
    end
  end

  // slot payload, qualified by the enables above
  always_ff @(posedge clk) begin
    if (bundleValid) begin
      outSlotInstr <= slotInstr;
      outSlotMagic <= slotMagic;
      outSlotOff   <= slotOff;
      outSlotClass <= slotClass;
      outJumpInstr <= jumpInstr;
      outJumpMagic <= jumpMagic;
      outJumpOff   <= jumpOff;
      outJumpClass <= jumpClass;
    end
  end

endmodule

//--- source/predecodeTop.sv
`timescale 1ns/1ps
`include "predecode_params.svh"

module predecodeTop
  import isa_pkg::*;
  import bundle_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  bundleT      bundle,
  input  parcelMaskT  flagBits,
  input  parcelOffT   startOff,
  input  logic        bundleValid,
  output instrWindowT outSlotInstr [`MAX_INSTR],
  output magicT       outSlotMagic [`MAX_INSTR],
  output parcelOffT   outSlotOff [`MAX_INSTR],
  output classT       outSlotClass [`MAX_INSTR],
  output instrEnT     outInstrEn,
  output logic        outError,
  output instrWindowT outJumpInstr [`MAX_JUMPS],
  output magicT       outJumpMagic [`MAX_JUMPS],
  output parcelOffT   outJumpOff [`MAX_JUMPS],
  output classT       outJumpClass [`MAX_JUMPS],
  output jumpEnT      outJumpEn,
  output logic        outHasJumps,
  output logic        outJumpError,
  output logic        outValid
);

  // per-parcel decode
  parcelMaskT  validStart;
  instrWindowT window [`NUM_PARCELS];
  magicT       magic [`NUM_PARCELS];
  classT       instrClass [`NUM_PARCELS];

  // combinational slot results
  instrWindowT slotInstr [`MAX_INSTR];
  magicT       slotMagic [`MAX_INSTR];
  parcelOffT   slotOff [`MAX_INSTR];
  classT       slotClass [`MAX_INSTR];
  instrEnT     instrEn;
  logic        error;
  instrWindowT jumpInstr [`MAX_JUMPS];
  magicT       jumpMagic [`MAX_JUMPS];
  parcelOffT   jumpOff [`MAX_JUMPS];
  classT       jumpClass [`MAX_JUMPS];
  jumpEnT      jumpEn;
  logic        hasJumps;
  logic        jumpError;

  // --------------------
  // classifiers
  // --------------------

  for (genvar k = 0; k < `NUM_PARCELS; k++) begin : gClass
    instrClassifier classifier (
      .window     (window[k]),
      .magic      (magic[k]),
      .flag       (flagBits[k]),
      .instrClass (instrClass[k])
    );
  end

  slotExtract slots (
    .bundle     (bundle),
    .startOff   (startOff),
    .instrClass (instrClass),
    .validStart (validStart),
    .window     (window),
    .magic      (magic),
    .slotInstr  (slotInstr),
    .slotMagic  (slotMagic),
    .slotOff    (slotOff),
    .slotClass  (slotClass),
    .instrEn    (instrEn),
    .error      (error)
  );

  jumpExtract jumps (
    .validStart (validStart),
    .window     (window),
    .magic      (magic),
    .instrClass (instrClass),
    .jumpInstr  (jumpInstr),
    .jumpMagic  (jumpMagic),
    .jumpOff    (jumpOff),
    .jumpClass  (jumpClass),
    .jumpEn     (jumpEn),
    .hasJumps   (hasJumps),
    .jumpError  (jumpError)
  );

  // --------------------
  // output stage
  // --------------------

  predecodeOutReg outReg (
    .clk          (clk),
    .reset        (reset),
    .bundleValid  (bundleValid),
    .slotInstr    (slotInstr),
    .slotMagic    (slotMagic),
    .slotOff      (slotOff),
    .slotClass    (slotClass),
    .instrEn      (instrEn),
    .error        (error),
    .jumpInstr    (jumpInstr),
    .jumpMagic    (jumpMagic),
    .jumpOff      (jumpOff),
    .jumpClass    (jumpClass),
    .jumpEn       (jumpEn),
    .hasJumps     (hasJumps),
    .jumpError    (jumpError),
    .outSlotInstr (outSlotInstr),
    .outSlotMagic (outSlotMagic),
    .outSlotOff   (outSlotOff),
    .outSlotClass (outSlotClass),
    .outInstrEn   (outInstrEn),
    .outError     (outError),
    .outJumpInstr (outJumpInstr),
    .outJumpMagic (outJumpMagic),
    .outJumpOff   (outJumpOff),
    .outJumpClass (outJumpClass),
    .outJumpEn    (outJumpEn),
    .outHasJumps  (outHasJumps),
    .outJumpError (outJumpError),
    .outValid     (outValid)
  );

endmodule

//--- tests/predecode_props.sv
`timescale 1ns/1ps

module predecode_props
  import isa_pkg::*;
  import bundle_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    bundleValid,
  input logic    outValid,
  input instrEnT outInstrEn,
  input jumpEnT  outJumpEn
);

  int assertFails = 0;

  // --------------------
  // valid pulse
  // --------------------

  validAfterStrobe: assert property (@(posedge clk) disable iff (reset)
    bundleValid |=> outValid)
    else begin
      $error("outValid missing one cycle after bundleValid");
      assertFails++;
    end

  validOnlyAfterStrobe: assert property (@(posedge clk) disable iff (reset)
    !bundleValid |=> !outValid)
    else begin
      $error("outValid high without a strobe the cycle before");
      assertFails++;
    end

  validLowAfterReset: assert property (@(posedge clk) reset |=> !outValid)
    else begin
      $error("outValid high right after reset");
      assertFails++;
    end

  // --------------------
  // enables fill from slot 0 up
  // --------------------

  instrEnContiguous: assert property (@(posedge clk) disable iff (reset)
    ((outInstrEn + 1) & outInstrEn) == 0)
    else begin
      $error("outInstrEn is not a low-order run");
      assertFails++;
    end

  jumpEnContiguous: assert property (@(posedge clk) disable iff (reset)
    ((outJumpEn + 1) & outJumpEn) == 0)
    else begin
      $error("outJumpEn is not a low-order run");
      assertFails++;
    end

endmodule

bind predecodeTop predecode_props props (.*);

//--- tests/predecode_tb.sv
`timescale 1ns/1ps
`include "predecode_params.svh"

module predecode_tb
  import isa_pkg::*;
  import bundle_pkg::*;
();

  localparam int NumBundles = 400;
  localparam int WaitLimit  = 10;
  localparam int MarkBase   = `NUM_PARCELS * `PARCEL_BITS;

  logic        clk = 1'b0;
  logic        reset;
  bundleT      bundle;
  parcelMaskT  flagBits;
  parcelOffT   startOff;
  logic        bundleValid;
  instrWindowT outSlotInstr [`MAX_INSTR];
  magicT       outSlotMagic [`MAX_INSTR];
  parcelOffT   outSlotOff [`MAX_INSTR];
  classT       outSlotClass [`MAX_INSTR];
  instrEnT     outInstrEn;
  logic        outError;
  instrWindowT outJumpInstr [`MAX_JUMPS];
  magicT       outJumpMagic [`MAX_JUMPS];
  parcelOffT   outJumpOff [`MAX_JUMPS];
  classT       outJumpClass [`MAX_JUMPS];
  jumpEnT      outJumpEn;
  logic        outHasJumps;
  logic        outJumpError;
  logic        outValid;

  // expected results from the model
  instrWindowT expSlotInstr [`MAX_INSTR];
  magicT       expSlotMagic [`MAX_INSTR];
  parcelOffT   expSlotOff [`MAX_INSTR];
  classT       expSlotClass [`MAX_INSTR];
  instrEnT     expInstrEn;
  logic        expError;
  instrWindowT expJumpInstr [`MAX_JUMPS];
  magicT       expJumpMagic [`MAX_JUMPS];
  parcelOffT   expJumpOff [`MAX_JUMPS];
  classT       expJumpClass [`MAX_JUMPS];
  jumpEnT      expJumpEn;
  logic        expHasJumps;
  logic        expJumpError;

  int seed = 32'h0ac5_5c6c;
  int errCount = 0;
  int checkCount = 0;
  bit timedOut = 1'b0;

  // one entry per class, the indirect opcode repeated for its sub forms
  opcodeT opTable [16] = '{8'd3, 8'd4, 8'd42, 8'd50, 8'd64, 8'd65, 8'd164, 8'd175,
                           8'd181, 8'd182, 8'd182, 8'd182, 8'd212, 8'hff, 8'd60, 8'd33};

  // jump opcodes only, used to overflow the jump slots
  opcodeT jumpOps [4] = '{8'd164, 8'd175, 8'd181, 8'd182};

  predecodeTop DUT (.*);

  always #2 clk = ~clk;

  // --------------------
  // compare tasks
  // --------------------

  task automatic checkWindow(string name, instrWindowT got, instrWindowT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkMagic(string name, magicT got, magicT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkOff(string name, parcelOffT got, parcelOffT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkClass(string name, classT got, classT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkInstrEn(string name, instrEnT got, instrEnT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkJumpEn(string name, jumpEnT got, jumpEnT exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // --------------------
  // reference model
  // --------------------

  // parcel 0 and positions past the bundle count as starts
  function automatic bit isStart(int j);
    if (j == 0 || j >= `NUM_PARCELS) begin
      return 1'b1;
    end
    return bundle[MarkBase + j - 1];
  endfunction

  function automatic classT classOf(instrWindowT win, magicT mg, logic flag);
    classT      c;
    opcodeT     op;
    logic [2:0] sub;
    c   = '0;
    op  = win[7:0];
    sub = win[15:13];
    if (mg[0]) begin
      if (op <= 39) begin
        if (op[2]) begin
          c[classMul] = 1'b1;
        end else begin
          c[classAlu] = 1'b1;
        end
      end else if (op <= 45) begin
        c[classShift] = 1'b1;
      end else if (op <= 53) begin
        c[classAlu] = 1'b1;
      end else if (op >= 64 && op <= 127) begin
        if (op[0]) begin
          c[classStore] = 1'b1;
        end else begin
          c[classLoad] = 1'b1;
        end
      end else if (op >= 160 && op <= 175) begin
        c[classJump] = 1'b1;
        c[classAlu]  = 1'b1;
      end else if (op == 181) begin
        c[classJump] = 1'b1;
      end else if (op == 182) begin
        if (sub == 0 || sub == 3) begin
          c[classJump]  = 1'b1;
          c[classIndir] = 1'b1;
        end else if (sub == 1 || sub == 2) begin
          c[classJump]  = 1'b1;
          c[classStore] = 1'b1;
        end
      end else if (op == 212) begin
        c[classMul] = 1'b1;
      end else if (op == 255) begin
        c[classSys] = 1'b1;
      end
    end
    c[classFlag] = flag;
    return c;
  endfunction

  task automatic computeExpected();
    instrWindowT win;
    magicT       mg;
    classT       cls;
    int          nInstr;
    int          nJump;
    nInstr = 0;
    nJump  = 0;
    for (int n = 0; n < `MAX_INSTR; n++) begin
      expSlotInstr[n] = '0;
      expSlotMagic[n] = '0;
      expSlotOff[n]   = '0;
      expSlotClass[n] = '0;
    end
    for (int m = 0; m < `MAX_JUMPS; m++) begin
      expJumpInstr[m] = '0;
      expJumpMagic[m] = '0;
      expJumpOff[m]   = '0;
      expJumpClass[m] = '0;
    end
    for (int k = 0; k < `NUM_PARCELS; k++) begin
      win = '0;
      for (int p = 0; p < `WINDOW_PARCELS; p++) begin
        if (k + p < `NUM_PARCELS) begin
          win[p*`PARCEL_BITS +: `PARCEL_BITS] = bundle[(k+p)*`PARCEL_BITS +: `PARCEL_BITS];
        end
      end
      for (int i = 0; i < `WINDOW_PARCELS - 1; i++) begin
        mg[i] = !isStart(k + 1 + i);
      end
      cls = classOf(win, mg, flagBits[k]);
      if (isStart(k) && k >= startOff) begin
        if (nInstr < `MAX_INSTR) begin
          expSlotInstr[nInstr] = win;
          expSlotMagic[nInstr] = mg;
          expSlotOff[nInstr]   = parcelOffT'(k);
          expSlotClass[nInstr] = cls;
        end
        nInstr++;
        if (cls[classJump]) begin
          if (nJump < `MAX_JUMPS) begin
            expJumpInstr[nJump] = win;
            expJumpMagic[nJump] = mg;
            expJumpOff[nJump]   = parcelOffT'(k);
            expJumpClass[nJump] = cls;
          end
          nJump++;
        end
      end
    end
    for (int n = 0; n < `MAX_INSTR; n++) begin
      expInstrEn[n] = (n < nInstr);
    end
    for (int m = 0; m < `MAX_JUMPS; m++) begin
      expJumpEn[m] = (m < nJump);
    end
    expError     = (nInstr > `MAX_INSTR) || (startOff == `NUM_PARCELS);
    expHasJumps  = (nJump > 0);
    expJumpError = (nJump > `MAX_JUMPS);
  endtask

  // --------------------
  // stimulus and checking
  // --------------------

  task automatic makeBundle();
    logic [31:0] r;
    logic [2:0]  mode;
    opcodeT      op;
    r    = $random(seed);
    mode = r[2:0];
    for (int k = 0; k < `NUM_PARCELS; k++) begin
      r = $random(seed);
      if (mode == 3'd4 && r[24]) begin
        op = jumpOps[r[5:4]];
      end else begin
        op = (r[3:0] < 12) ? opTable[r[7:4]] : r[15:8];
      end
      bundle[k*`PARCEL_BITS +: `PARCEL_BITS] = {r[23:16], op};
    end
    // sparse, dense, all-start, two-parcel or uniform start marks
    for (int j = 0; j < `NUM_PARCELS - 1; j++) begin
      r = $random(seed);
      case (mode)
        3'd0:    bundle[MarkBase + j] = (r[2:0] == 0);
        3'd1:    bundle[MarkBase + j] = (r[2:0] != 0);
        3'd2:    bundle[MarkBase + j] = 1'b1;
        3'd4:    bundle[MarkBase + j] = j[0];
        default: bundle[MarkBase + j] = r[0];
      endcase
    end
    r = $random(seed);
    bundle[`BUNDLE_BITS-1] = r[0];
    flagBits = r[15:1];
    startOff = (r[18:16] == 0) ? parcelOffT'(r[23:20]) : parcelOffT'(r[25:24]);
  endtask

  task automatic waitValid(output bit ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
      ok = (outValid === 1'b1);
    end
    if (!ok) begin
      $display("timeout: outValid did not rise within %0d cycles", WaitLimit);
    end
  endtask

  task automatic checkAll();
    for (int n = 0; n < `MAX_INSTR; n++) begin
      checkWindow($sformatf("outSlotInstr[%0d]", n), outSlotInstr[n], expSlotInstr[n]);
      checkMagic($sformatf("outSlotMagic[%0d]", n), outSlotMagic[n], expSlotMagic[n]);
      checkOff($sformatf("outSlotOff[%0d]", n), outSlotOff[n], expSlotOff[n]);
      checkClass($sformatf("outSlotClass[%0d]", n), outSlotClass[n], expSlotClass[n]);
    end
    for (int m = 0; m < `MAX_JUMPS; m++) begin
      checkWindow($sformatf("outJumpInstr[%0d]", m), outJumpInstr[m], expJumpInstr[m]);
      checkMagic($sformatf("outJumpMagic[%0d]", m), outJumpMagic[m], expJumpMagic[m]);
      checkOff($sformatf("outJumpOff[%0d]", m), outJumpOff[m], expJumpOff[m]);
      checkClass($sformatf("outJumpClass[%0d]", m), outJumpClass[m], expJumpClass[m]);
    end
    checkInstrEn("outInstrEn", outInstrEn, expInstrEn);
    checkJumpEn("outJumpEn", outJumpEn, expJumpEn);
    checkBit("outError", outError, expError);
    checkBit("outHasJumps", outHasJumps, expHasJumps);
    checkBit("outJumpError", outJumpError, expJumpError);
  endtask

  initial begin
    logic [31:0] r;
    bit          ok;
    reset       = 1'b1;
    bundle      = '0;
    flagBits    = '0;
    startOff    = '0;
    bundleValid = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // nothing strobed yet
    checkBit("outValid", outValid, 1'b0);
    checkInstrEn("outInstrEn", outInstrEn, '0);
    checkJumpEn("outJumpEn", outJumpEn, '0);
    checkBit("outError", outError, 1'b0);
    checkBit("outJumpError", outJumpError, 1'b0);
    checkBit("outHasJumps", outHasJumps, 1'b0);

    for (int i = 0; i < NumBundles && !timedOut; i++) begin
      makeBundle();
      bundleValid = 1'b1;
      computeExpected();
      waitValid(ok);
      if (!ok) begin
        timedOut = 1'b1;
      end else begin
        checkAll();
        r = $random(seed);
        // mostly back-to-back, sometimes an idle gap with new inputs
        if (r[1:0] == 0) begin
          bundleValid = 1'b0;
          makeBundle();
          repeat (2) @(negedge clk);
          checkBit("outValid", outValid, 1'b0);
          checkAll();
        end
      end
    end
    bundleValid = 1'b0;
    @(negedge clk);

    $display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
             checkCount, errCount, DUT.props.assertFails, timedOut);
    if (errCount == 0 && DUT.props.assertFails == 0 && !timedOut) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/isa_pkg.sv
source/bundle_pkg.sv
source/instrClassifier.sv
source/slotExtract.sv
source/jumpExtract.sv
source/predecodeOutReg.sv
source/predecodeTop.sv
tests/predecode_props.sv
tests/predecode_tb.sv

//--- Bender.yml
package:
  name: predecode

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/bundle_pkg.sv
      - source/instrClassifier.sv
      - source/slotExtract.sv
      - source/jumpExtract.sv
      - source/predecodeOutReg.sv
      - source/predecodeTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/predecode_props.sv
      - tests/predecode_tb.sv
